// ==== source/ex_settings.svh ====
// Width settings for the EX stage
// Word, register address, hart ID and exception code widths

`ifndef EX_SETTINGS_SVH
`define EX_SETTINGS_SVH

////////////////////////////////////////
// Datapath
////////////////////////////////////////

// Integer datapath width
`define EX_WORD_W      32

// Register file index, 32 GPRs
`define EX_REG_ADDR_W  5

////////////////////////////////////////
// Hart and exception
////////////////////////////////////////

// Two interleaved harts
`define EX_HART_W      1

// Exception code carried down the pipe
`define EX_EXP_W       4

`endif

// ==== source/ex_ops_pkg.sv ====
// Operation types for the EX stage
// Word typedefs plus ALU, compare, memory and result-select encodings

`include "ex_settings.svh"

package ex_ops_pkg;

    // Meaningful widths
    typedef logic [`EX_WORD_W-1:0]     word_t;      // One data word
    typedef logic [`EX_REG_ADDR_W-1:0] reg_addr_t;  // GPR number
    typedef logic [`EX_HART_W-1:0]     hart_id_t;   // Hart number
    typedef logic [`EX_EXP_W-1:0]      exp_code_t;  // Exception code

    // ALU operations
    typedef enum logic [3:0] {
        ALU_ADD   = 4'd0,
        ALU_SUB   = 4'd1,
        ALU_AND   = 4'd2,
        ALU_OR    = 4'd3,
        ALU_XOR   = 4'd4,
        ALU_SLL   = 4'd5,
        ALU_SRL   = 4'd6,
        ALU_SRA   = 4'd7,
        ALU_SLT   = 4'd8,
        ALU_SLTU  = 4'd9,
        ALU_PASS1 = 4'd10   // LUI, passes operand 1
    } alu_op_t;

    // Compare operations
    typedef enum logic [2:0] {
        CMP_EQ  = 3'd0,
        CMP_NE  = 3'd1,
        CMP_LT  = 3'd2,
        CMP_GE  = 3'd3,
        CMP_LTU = 3'd4,
        CMP_GEU = 3'd5
    } cmp_op_t;

    // Memory access type, NONE must stay 0
    typedef enum logic [2:0] {
        MEM_NONE = 3'd0,
        MEM_LW   = 3'd1,
        MEM_LH   = 3'd2,
        MEM_LB   = 3'd3,
        MEM_SW   = 3'd4,
        MEM_SH   = 3'd5,
        MEM_SB   = 3'd6
    } mem_op_t;

    // EX result source
    typedef enum logic [1:0] {
        OUT_ALU  = 2'd0,
        OUT_CMP  = 2'd1,
        OUT_PCN  = 2'd2,   // PC + 4 from ID
        OUT_ZERO = 2'd3
    } out_sel_t;

endpackage

// ==== source/ex_pipe_pkg.sv ====
// Pipeline records for the EX stage
// ID/EX input, EX/MEM output and branch outcome structs

package ex_pipe_pkg;

    import ex_ops_pkg::*;

    ////////////////////////////////////////
    // ID/EX record
    ////////////////////////////////////////
    typedef struct packed {
        logic      is_jalr;      // JALR, target bit 0 cleared
        exp_code_t exp_code;
        word_t     pc;
        logic      en;           // Valid instruction
        alu_op_t   alu_op;
        word_t     alu_in_0;
        word_t     alu_in_1;     // Imm for stores
        cmp_op_t   cmp_op;
        word_t     cmp_in_0;
        word_t     cmp_in_1;
        logic      jump_taken;   // Unconditional jump
        mem_op_t   mem_op;
        word_t     mem_wr_data;
        reg_addr_t rd_addr;
        logic      gpr_we;       // Clear for branches
        hart_id_t  hart_id;
        out_sel_t  out_sel;
        word_t     pcn_data;     // PC + 4
    } id_ex_t;

    ////////////////////////////////////////
    // EX/MEM record
    ////////////////////////////////////////
    typedef struct packed {
        exp_code_t exp_code;
        word_t     pc;
        logic      en;
        mem_op_t   mem_op;
        word_t     mem_wr_data;  // After forwarding
        reg_addr_t rd_addr;
        logic      gpr_we;
        word_t     out;          // Selected EX result
        hart_id_t  hart_id;
    } ex_mem_t;

    // Branch outcome to IF
    typedef struct packed {
        logic  taken;
        word_t addr;
    } branch_t;

endpackage

// ==== source/ex_alu.sv ====
// Integer ALU for the EX stage
// Add/sub, logic, shifts, set-less-than and operand pass

`timescale 1ns/10ps

`include "ex_settings.svh"

module ex_alu (
    input  ex_ops_pkg::word_t   in_0,
    input  ex_ops_pkg::word_t   in_1,
    input  ex_ops_pkg::alu_op_t op,
    output ex_ops_pkg::word_t   result
);

    import ex_ops_pkg::*;

    // Shift amount width, 5 for a 32-bit word
    localparam int SHAMT_W = $clog2(`EX_WORD_W);

    logic [SHAMT_W-1:0] shamt;   // Low bits of operand 1
    logic               lt_s;    // Signed less-than
    logic               lt_u;    // Unsigned less-than

    assign shamt = in_1[SHAMT_W-1:0];
    assign lt_s  = $signed(in_0) < $signed(in_1);
    assign lt_u  = in_0 < in_1;

    ////////////////////////////////////////
    // Operation select
    ////////////////////////////////////////
    always_comb begin
        case (op)
            ALU_ADD:   result = in_0 + in_1;
            ALU_SUB:   result = in_0 - in_1;
            ALU_AND:   result = in_0 & in_1;
            ALU_OR:    result = in_0 | in_1;
            ALU_XOR:   result = in_0 ^ in_1;
            ALU_SLL:   result = in_0 << shamt;
            ALU_SRL:   result = in_0 >> shamt;
            // Arithmetic shift keeps the sign
            ALU_SRA:   result = word_t'($signed(in_0) >>> shamt);
            ALU_SLT:   result = word_t'(lt_s);       // 0 or 1
            ALU_SLTU:  result = word_t'(lt_u);
            ALU_PASS1: result = in_1;                // LUI
            default:   result = '0;                  // Unused codes
        endcase
    end

endmodule

// ==== source/ex_cmp.sv ====
// Comparator for branches and set-style results
// Equality, signed and unsigned ordering

`timescale 1ns/10ps

module ex_cmp (
    input  ex_ops_pkg::word_t   in_0,
    input  ex_ops_pkg::word_t   in_1,
    input  ex_ops_pkg::cmp_op_t op,
    output logic                is_true
);

    import ex_ops_pkg::*;

    logic eq;     // in_0 == in_1
    logic lt_s;   // Signed order
    logic lt_u;   // Unsigned order

    assign eq   = in_0 == in_1;
    assign lt_s = $signed(in_0) < $signed(in_1);
    assign lt_u = in_0 < in_1;

    always_comb begin
        case (op)
            CMP_EQ:  is_true = eq;
            CMP_NE:  is_true = !eq;
            CMP_LT:  is_true = lt_s;
            CMP_GE:  is_true = !lt_s;    // BGE, not less
            CMP_LTU: is_true = lt_u;
            CMP_GEU: is_true = !lt_u;
            default: is_true = 1'b0;     // Never true
        endcase
    end

endmodule

// ==== source/ex_ctrl.sv ====
// EX stage control
// Forwarding, result select, branch resolution, EX/MEM load and kill

`timescale 1ns/10ps

module ex_ctrl (
    input  ex_pipe_pkg::id_ex_t  id,
    input  logic                 rs1_fwd,
    input  logic                 rs2_fwd,
    input  ex_ops_pkg::word_t    mem_fwd_data,
    input  logic                 stall,
    input  logic                 flush,
    input  ex_ops_pkg::word_t    alu_out,
    input  logic                 cmp_true,
    output ex_ops_pkg::word_t    alu_in_0,
    output ex_ops_pkg::word_t    alu_in_1,
    output ex_ops_pkg::alu_op_t  alu_op,
    output ex_ops_pkg::word_t    cmp_in_0,
    output ex_ops_pkg::word_t    cmp_in_1,
    output ex_ops_pkg::cmp_op_t  cmp_op,
    output ex_ops_pkg::word_t    fwd_data,
    output ex_pipe_pkg::branch_t br,
    output ex_pipe_pkg::ex_mem_t next,
    output logic                 load,
    output logic                 kill
);

    import ex_ops_pkg::*;

    word_t st_data;   // Store data after forwarding
    word_t result;    // Selected EX result

    ////////////////////////////////////////
    // Forwarding from MEM
    ////////////////////////////////////////
    // Load in MEM feeding the instruction in EX
    assign alu_in_0 = rs1_fwd ? mem_fwd_data : id.alu_in_0;
    assign st_data  = rs2_fwd ? mem_fwd_data : id.mem_wr_data;
    // Operand 1 holds the store offset, never forwarded
    assign alu_in_1 = id.alu_in_1;
    assign alu_op   = id.alu_op;

    assign cmp_in_0 = id.cmp_in_0;   // Regs already read in ID
    assign cmp_in_1 = id.cmp_in_1;
    assign cmp_op   = id.cmp_op;

    // Result select
    always_comb begin
        case (id.out_sel)
            OUT_ALU: result = alu_out;
            OUT_CMP: result = word_t'(cmp_true);   // Zero-extended
            OUT_PCN: result = id.pcn_data;         // Link address
            default: result = '0;
        endcase
    end

    assign fwd_data = result;   // Bypass to ID

    ////////////////////////////////////////
    // Branch and jump resolution
    ////////////////////////////////////////
    assign br.addr  = id.is_jalr ? (alu_out & ~word_t'(1)) : alu_out;
    // Branches write no register, jumps always taken
    assign br.taken = (cmp_true && !id.gpr_we) || id.jump_taken;

    // Next EX/MEM record
    always_comb begin
        next.exp_code    = id.exp_code;
        next.pc          = id.pc;
        next.en          = id.en;
        next.mem_op      = id.mem_op;
        next.mem_wr_data = st_data;
        next.rd_addr     = id.rd_addr;
        next.gpr_we      = id.gpr_we;
        next.out         = result;
        next.hart_id     = id.hart_id;
    end

    // Register actions, kill has priority in the register
    assign load = !stall;
    assign kill = flush;

endmodule

// ==== source/ex_mem_reg.sv ====
// EX/MEM pipeline register
// Hold on stall, clear on flush, registered memory-access flag

`timescale 1ns/10ps

module ex_mem_reg (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 load,
    input  logic                 kill,
    input  ex_pipe_pkg::ex_mem_t next,
    output ex_pipe_pkg::ex_mem_t ex,
    output logic                 access_mem
);

    import ex_ops_pkg::*;

    logic next_access;   // Valid load or store in next

    assign next_access = (next.mem_op != MEM_NONE) && next.en;

    ////////////////////////////////////////
    // Record and flag
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            ex         <= '0;       // mem_op reads as NONE
            access_mem <= 1'b0;
        end else if (kill) begin
            // Bubble, wins even under stall
            ex         <= '0;
            access_mem <= 1'b0;
        end else if (load) begin
            ex         <= next;
            access_mem <= next_access;
        end
        // Stall, hold the current record
    end

endmodule

// ==== source/ex_stage.sv ====
// EX stage top level
// Control, ALU, comparator and EX/MEM register instances

`timescale 1ns/10ps

module ex_stage (
    input  logic                 clk,
    input  logic                 rst,
    // Hazard unit
    input  logic                 stall,
    input  logic                 flush,
    // ID/EX record
    input  ex_pipe_pkg::id_ex_t  id,
    // Forwarding from MEM
    input  logic                 rs1_fwd,
    input  logic                 rs2_fwd,
    input  ex_ops_pkg::word_t    mem_fwd_data,
    // To MEM, ID and IF
    output ex_pipe_pkg::ex_mem_t ex,
    output ex_ops_pkg::word_t    fwd_data,
    output ex_pipe_pkg::branch_t br,
    // To data cache
    output logic                 access_mem,
    output ex_ops_pkg::word_t    alu_out
);

    import ex_ops_pkg::*;
    import ex_pipe_pkg::*;

    word_t   alu_in_0;
    word_t   alu_in_1;
    alu_op_t alu_op;
    word_t   cmp_in_0;
    word_t   cmp_in_1;
    cmp_op_t cmp_op;
    logic    cmp_true;
    ex_mem_t next;      // Record for the register
    logic    load;
    logic    kill;

    ////////////////////////////////////////
    // Control
    ////////////////////////////////////////
    ex_ctrl u_ctrl (
        .id           (id),
        .rs1_fwd      (rs1_fwd),
        .rs2_fwd      (rs2_fwd),
        .mem_fwd_data (mem_fwd_data),
        .stall        (stall),
        .flush        (flush),
        .alu_out      (alu_out),
        .cmp_true     (cmp_true),
        .alu_in_0     (alu_in_0),
        .alu_in_1     (alu_in_1),
        .alu_op       (alu_op),
        .cmp_in_0     (cmp_in_0),
        .cmp_in_1     (cmp_in_1),
        .cmp_op       (cmp_op),
        .fwd_data     (fwd_data),
        .br           (br),
        .next         (next),
        .load         (load),
        .kill         (kill)
    );

    // Datapath
    ex_alu u_alu (
        .in_0   (alu_in_0),
        .in_1   (alu_in_1),
        .op     (alu_op),
        .result (alu_out)
    );

    ex_cmp u_cmp (
        .in_0    (cmp_in_0),
        .in_1    (cmp_in_1),
        .op      (cmp_op),
        .is_true (cmp_true)
    );

    ////////////////////////////////////////
    // EX/MEM register
    ////////////////////////////////////////
    ex_mem_reg u_ex_mem_reg (
        .clk        (clk),
        .rst        (rst),
        .load       (load),
        .kill       (kill),
        .next       (next),
        .ex         (ex),
        .access_mem (access_mem)
    );

endmodule

// ==== sim/tb_ex_model.svh ====
// Testbench model for the EX stage
// Galois LFSR step and reference function for the expected outputs

`ifndef TB_EX_MODEL_SVH
`define TB_EX_MODEL_SVH

// Expected combinational outputs and next EX/MEM record
typedef struct packed {
    word_t   alu_out;
    word_t   fwd_data;
    branch_t br;
    ex_mem_t next;
} expect_t;

// Galois LFSR with taps x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

////////////////////////////////////////
// Reference stage
////////////////////////////////////////
function automatic expect_t stage_model(input id_ex_t d, input logic fwd_a,
                                        input logic fwd_b, input word_t mem_data);
    expect_t    e;
    word_t      a;
    word_t      b;
    logic       ct;      // Compare outcome
    logic [4:0] sh;
    a  = fwd_a ? mem_data : d.alu_in_0;   // Operand 0 may come from MEM
    b  = d.alu_in_1;                      // Immediate path is never forwarded
    sh = b[4:0];
    case (d.alu_op)
        ALU_ADD:   e.alu_out = a + b;
        ALU_SUB:   e.alu_out = a + ~b + word_t'(1);   // Two's complement
        ALU_AND:   e.alu_out = a & b;
        ALU_OR:    e.alu_out = a | b;
        ALU_XOR:   e.alu_out = a ^ b;
        ALU_SLL:   e.alu_out = a << sh;
        ALU_SRL:   e.alu_out = a >> sh;
        // Sign bits fill the vacated top
        ALU_SRA:   e.alu_out = (a >> sh) | (~({32{1'b1}} >> sh) & {32{a[31]}});
        ALU_SLT:   e.alu_out = word_t'((a[31] != b[31]) ? a[31] : (a < b));
        ALU_SLTU:  e.alu_out = word_t'(a < b);
        ALU_PASS1: e.alu_out = b;
        default:   e.alu_out = '0;
    endcase
    case (d.cmp_op)
        CMP_EQ:  ct = d.cmp_in_0 == d.cmp_in_1;
        CMP_NE:  ct = d.cmp_in_0 != d.cmp_in_1;
        CMP_LT:  ct = (d.cmp_in_0[31] != d.cmp_in_1[31]) ? d.cmp_in_0[31]
                                                          : (d.cmp_in_0 < d.cmp_in_1);
        CMP_GE:  ct = $signed(d.cmp_in_0) >= $signed(d.cmp_in_1);
        CMP_LTU: ct = d.cmp_in_0 < d.cmp_in_1;
        CMP_GEU: ct = d.cmp_in_0 >= d.cmp_in_1;
        default: ct = 1'b0;
    endcase
    case (d.out_sel)
        OUT_ALU: e.fwd_data = e.alu_out;
        OUT_CMP: e.fwd_data = word_t'(ct);
        OUT_PCN: e.fwd_data = d.pcn_data;
        default: e.fwd_data = '0;   // OUT_ZERO
    endcase
    e.br.taken = d.jump_taken | (ct & ~d.gpr_we);   // Branch = no GPR write
    e.br.addr  = {e.alu_out[31:1], e.alu_out[0] & ~d.is_jalr};
    e.next.exp_code    = d.exp_code;
    e.next.pc          = d.pc;
    e.next.en          = d.en;
    e.next.mem_op      = d.mem_op;
    e.next.mem_wr_data = fwd_b ? mem_data : d.mem_wr_data;
    e.next.rd_addr     = d.rd_addr;
    e.next.gpr_we      = d.gpr_we;
    e.next.out         = e.fwd_data;
    e.next.hart_id     = d.hart_id;
    return e;
endfunction

`endif

// ==== sim/tb_ex_stage.sv ====
// Testbench for the EX stage
// Clock, reset, random stimulus, output checks, watchdog and report

`timescale 1ns/10ps

module tb_ex_stage;

    import ex_ops_pkg::*;
    import ex_pipe_pkg::*;

    `include "tb_ex_model.svh"

    localparam int MODE_ALU    = 0;
    localparam int MODE_BRANCH = 1;
    localparam int MODE_FWD    = 2;
    localparam int MODE_PIPE   = 3;
    localparam int RUN_CYCLES  = 4 + 200 + 100 + 100 + 150 + 10;   // Reset, tests, gaps

    logic        clk = 1'b0;
    logic        rst;
    logic        stall;
    logic        flush;
    id_ex_t      id;
    logic        rs1_fwd;
    logic        rs2_fwd;
    word_t       mem_fwd_data;
    ex_mem_t     ex;
    word_t       fwd_data;
    branch_t     br;
    logic        access_mem;
    word_t       alu_out;

    logic [31:0] lfsr = 32'h1071;
    logic        checking = 1'b0;   // Compare process armed
    logic        pend_on;
    expect_t     expd;
    ex_mem_t     model_ex = '0;     // Model EX/MEM register
    logic        model_acc = 1'b0;
    int          n_checks = 0;
    int          n_errors = 0;
    int          checks_at_start = 0;
    int          errors_at_start = 0;

    ex_stage DUT (
        .clk          (clk),
        .rst          (rst),
        .stall        (stall),
        .flush        (flush),
        .id           (id),
        .rs1_fwd      (rs1_fwd),
        .rs2_fwd      (rs2_fwd),
        .mem_fwd_data (mem_fwd_data),
        .ex           (ex),
        .fwd_data     (fwd_data),
        .br           (br),
        .access_mem   (access_mem),
        .alu_out      (alu_out)
    );

    always #10 clk = ~clk;   // 20 ns period

    // One LFSR step per bit, newest bit in the LSB
    function automatic word_t take_bits(input int n);
        word_t r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic logic take_bit();
        lfsr = lfsr_step(lfsr);
        return lfsr[0];
    endfunction

    function automatic id_ex_t random_id();
        id_ex_t d;
        d.is_jalr     = take_bit();
        d.exp_code    = exp_code_t'(take_bits(4));
        d.pc          = take_bits(32);
        d.en          = take_bit();
        d.alu_op      = alu_op_t'(4'(take_bits(4) % 11));
        d.alu_in_0    = take_bits(32);
        d.alu_in_1    = take_bits(32);
        d.cmp_op      = cmp_op_t'(3'(take_bits(3) % 6));
        d.cmp_in_0    = take_bits(32);
        d.cmp_in_1    = take_bits(32);
        d.jump_taken  = take_bit();
        d.mem_op      = mem_op_t'(3'(take_bits(3) % 7));
        d.mem_wr_data = take_bits(32);
        d.rd_addr     = reg_addr_t'(take_bits(5));
        d.gpr_we      = take_bit();
        d.hart_id     = hart_id_t'(take_bits(1));
        d.out_sel     = out_sel_t'(take_bits(2));
        d.pcn_data    = take_bits(32);
        return d;
    endfunction

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////
    task automatic check_word(input string name, input word_t expv, input word_t actv);
        n_checks++;
        assert (actv === expv) else begin
            $display("FAILED at %0t: %s expected %h, got %h", $realtime, name, expv, actv);
            n_errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic expv, input logic actv);
        n_checks++;
        assert (actv === expv) else begin
            $display("FAILED at %0t: %s expected %b, got %b", $realtime, name, expv, actv);
            n_errors++;
        end
    endtask

    task automatic check_record(input string name, input ex_mem_t expv, input ex_mem_t actv);
        n_checks++;
        assert (actv === expv) else begin
            $display("FAILED at %0t: %s expected %h, got %h", $realtime, name, expv, actv);
            n_errors++;
        end
    endtask

    // Combinational outputs at the falling edge, register one edge later
    always begin
        @(negedge clk);
        pend_on = checking;
        expd    = stage_model(id, rs1_fwd, rs2_fwd, mem_fwd_data);
        if (checking) begin
            check_word("alu_out", expd.alu_out, alu_out);
            check_word("fwd_data", expd.fwd_data, fwd_data);
            check_bit("br.taken", expd.br.taken, br.taken);
            check_word("br.addr", expd.br.addr, br.addr);
        end
        @(posedge clk);
        if (rst || flush) begin   // Flush beats stall
            model_ex  = '0;
            model_acc = 1'b0;
        end else if (!stall) begin
            model_ex  = expd.next;
            model_acc = (expd.next.mem_op != MEM_NONE) && expd.next.en;
        end
        #1;
        if (pend_on) begin
            check_record("ex", model_ex, ex);
            check_bit("access_mem", model_acc, access_mem);
        end
    end

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////
    task automatic run_vectors(input int mode, input int count);
        id_ex_t d;
        for (int k = 0; k < count; k++) begin
            @(posedge clk);
            #2;
            d       = random_id();
            stall   = 1'b0;
            flush   = 1'b0;
            rs1_fwd = 1'b0;
            rs2_fwd = 1'b0;
            case (mode)
                MODE_ALU: begin
                    d.gpr_we = 1'b1;
                end
                MODE_BRANCH: begin
                    d.jump_taken = (take_bits(2) == 0);     // Jumps write the link
                    d.gpr_we     = d.jump_taken;
                    d.is_jalr    = d.jump_taken & take_bit();
                    d.out_sel    = d.jump_taken ? OUT_PCN : OUT_ZERO;
                    d.alu_op     = ALU_ADD;                 // Target = base + offset
                    d.mem_op     = MEM_NONE;
                    if (take_bit()) begin
                        d.cmp_in_1 = d.cmp_in_0;            // Hit the equal cases
                    end
                end
                MODE_FWD: begin
                    rs1_fwd      = 1'b1;
                    rs2_fwd      = 1'b1;
                    d.en         = 1'b1;
                    d.alu_op     = ALU_ADD;                 // Address = base + imm
                    d.jump_taken = 1'b0;
                    d.mem_op     = mem_op_t'(3'(4 + take_bits(2) % 3));   // SW, SH, SB
                end
                MODE_PIPE: begin
                    stall   = take_bit();
                    flush   = (take_bits(2) == 0);
                    rs1_fwd = take_bit();
                    rs2_fwd = take_bit();
                end
                default: ;
            endcase
            id           = d;
            mem_fwd_data = take_bits(32);
        end
    endtask

    task automatic end_test(input string name);
        @(posedge clk);
        #1.5;   // After the last register check
        $display("test %-8s %0d checks, %0d errors", name,
                 n_checks - checks_at_start, n_errors - errors_at_start);
        checks_at_start = n_checks;
        errors_at_start = n_errors;
    endtask

    initial begin
        rst          = 1'b1;
        stall        = 1'b0;
        flush        = 1'b0;
        id           = '0;
        rs1_fwd      = 1'b0;
        rs2_fwd      = 1'b0;
        mem_fwd_data = '0;
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;
        // Record straight out of reset
        check_bit("ex.en", 1'b0, ex.en);
        check_bit("ex.gpr_we", 1'b0, ex.gpr_we);
        check_bit("access_mem", 1'b0, access_mem);
        check_word("ex.mem_op", word_t'(MEM_NONE), word_t'(ex.mem_op));
        end_test("reset");
        checking = 1'b1;
        run_vectors(MODE_ALU, 200);
        end_test("alu");
        run_vectors(MODE_BRANCH, 100);
        end_test("branch");
        run_vectors(MODE_FWD, 100);
        end_test("forward");
        run_vectors(MODE_PIPE, 150);
        end_test("pipe");
        $display("total: %0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(RUN_CYCLES * 20 + 400);
        $display("Timeout: the tests did not finish in the expected time");
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+source
+incdir+sim
source/ex_ops_pkg.sv
source/ex_pipe_pkg.sv
source/ex_alu.sv
source/ex_cmp.sv
source/ex_ctrl.sv
source/ex_mem_reg.sv
source/ex_stage.sv
sim/tb_ex_stage.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the EX stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module tb_ex_stage -o tb_ex_stage
./obj_dir/tb_ex_stage | tee sim.log

if grep -q '\*\*\* PASSED \*\*\*' sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi
